/* Bender.yml */
package:
  name: sf_video

sources:
  - verilog/sf_video_pkg.sv
  - verilog/pixel_timing.sv
  - verilog/plane_serializer.sv
  - verilog/layer_priority_mixer.sv
  - verilog/video_cfg_regs.sv
  - verilog/sf_video_top.sv
  - target: simulation
    files:
      - testbench/sf_video_assertions.sv
      - testbench/tb_sf_video.sv

/* filelist.f */
verilog/sf_video_pkg.sv
verilog/pixel_timing.sv
verilog/plane_serializer.sv
verilog/layer_priority_mixer.sv
verilog/video_cfg_regs.sv
verilog/sf_video_top.sv
testbench/sf_video_assertions.sv
testbench/tb_sf_video.sv

/* testbench/sf_video_assertions.sv */
// bound protocol and pixel stream checks on the video pixel path top level
`timescale 1ns/10ps

module sf_video_assertions (
   input logic clk,
   input logic CR,
   input logic psel_i,
   input logic penable_i,
   input logic pready_o,
   input logic pslverr_o,
   input logic tile_load_o,
   input logic pixel_valid_o
);

   // ========================================================================
   // pixel stream
   // ========================================================================

   valid_single_pulse: assert property (
      @(posedge clk) disable iff (!CR) pixel_valid_o |=> !pixel_valid_o
   ) else $error("pixel_valid_o high in two consecutive cycles");

   // load strobe is a pixel enable, so a valid pulse follows it
   valid_after_load: assert property (
      @(posedge clk) disable iff (!CR) tile_load_o |=> pixel_valid_o
   ) else $error("no pixel_valid_o in the cycle after tile_load_o");

   // ========================================================================
   // apb
   // ========================================================================

   ready_in_access: assert property (
      @(posedge clk) disable iff (!CR) (psel_i && penable_i) |-> pready_o
   ) else $error("pready_o low in an access cycle");

   slverr_in_access: assert property (
      @(posedge clk) disable iff (!CR) pslverr_o |-> penable_i
   ) else $error("pslverr_o high outside an access cycle");

endmodule

bind sf_video_top sf_video_assertions i_sf_video_assertions (
   .clk           (clk),
   .CR            (CR),
   .psel_i        (psel_i),
   .penable_i     (penable_i),
   .pready_o      (pready_o),
   .pslverr_o     (pslverr_o),
   .tile_load_o   (tile_load_o),
   .pixel_valid_o (pixel_valid_o)
);

/* testbench/tb_sf_video.sv */
// testbench for the two-layer tile pixel path, table driven with apb setup
`timescale 1ns/10ps

module tb_sf_video;

   localparam int CLK_DIV = 8;
   localparam int N_ROWS  = 12;
   localparam sf_video_pkg::apb_addr_t CTRL_A =
      sf_video_pkg::apb_addr_t'(sf_video_pkg::CTRL_ADDR);
   localparam sf_video_pkg::apb_addr_t BANK_A =
      sf_video_pkg::apb_addr_t'(sf_video_pkg::BANK_ADDR);
   localparam sf_video_pkg::apb_addr_t UNMAPPED_A = 4'h9;

   logic                       clk;
   logic                       CR;
   sf_video_pkg::apb_addr_t    paddr_i;
   logic                       psel_i;
   logic                       penable_i;
   logic                       pwrite_i;
   sf_video_pkg::apb_data_t    pwdata_i;
   sf_video_pkg::apb_data_t    prdata_o;
   logic                       pready_o;
   logic                       pslverr_o;
   sf_video_pkg::plane_byte_t  fg_plane0_i;
   sf_video_pkg::plane_byte_t  fg_plane1_i;
   sf_video_pkg::plane_byte_t  bg_plane0_i;
   sf_video_pkg::plane_byte_t  bg_plane1_i;
   logic                       tile_load_o;
   sf_video_pkg::color_index_t pixel_o;
   logic                       pixel_valid_o;

   // stimulus table of tile bytes, register values and expected pixels
   sf_video_pkg::plane_byte_t  fg0_t [N_ROWS];
   sf_video_pkg::plane_byte_t  fg1_t [N_ROWS];
   sf_video_pkg::plane_byte_t  bg0_t [N_ROWS];
   sf_video_pkg::plane_byte_t  bg1_t [N_ROWS];
   logic [7:0]                 ctrl_t [N_ROWS];
   logic [7:0]                 bank_t [N_ROWS];
   logic                       stream_t [N_ROWS];
   sf_video_pkg::color_index_t exp_t [N_ROWS][8];

   integer seed;
   integer errors;
   integer err_mark;
   integer tests;
   integer failed;

   sf_video_top #(
      .CLK_DIV (CLK_DIV)
   ) i_sf_video_top (
      .clk           (clk),
      .CR            (CR),
      .paddr_i       (paddr_i),
      .psel_i        (psel_i),
      .penable_i     (penable_i),
      .pwrite_i      (pwrite_i),
      .pwdata_i      (pwdata_i),
      .prdata_o      (prdata_o),
      .pready_o      (pready_o),
      .pslverr_o     (pslverr_o),
      .fg_plane0_i   (fg_plane0_i),
      .fg_plane1_i   (fg_plane1_i),
      .bg_plane0_i   (bg_plane0_i),
      .bg_plane1_i   (bg_plane1_i),
      .tile_load_o   (tile_load_o),
      .pixel_o       (pixel_o),
      .pixel_valid_o (pixel_valid_o)
   );

   always #10 clk = ~clk;

   // ========================================================================
   // reference model of serializer order and layer priority
   // ========================================================================

   function automatic sf_video_pkg::color_index_t expected_index(input int i, input int k);
      int         fb;
      int         bb;
      logic [1:0] fc;
      logic [1:0] bc;
      // pixel k is bit 7-k, or bit k when the layer is flipped
      fb = ctrl_t[i][0] ? k : 7 - k;
      bb = ctrl_t[i][1] ? k : 7 - k;
      fc = {fg1_t[i][fb], fg0_t[i][fb]};
      bc = {bg1_t[i][bb], bg0_t[i][bb]};
      if (fc == 2'd0 && bc == 2'd0)
         return 5'd0;
      if (fc != 2'd0 && (bc == 2'd0 || ctrl_t[i][2]))
         return {1'b1, bank_t[i][1:0], fc};
      return {1'b0, bank_t[i][3:2], bc};
   endfunction

   task automatic set_row(input int i, input logic [7:0] f0, input logic [7:0] f1,
                          input logic [7:0] b0, input logic [7:0] b1,
                          input logic [7:0] c, input logic [7:0] b, input logic s);
      fg0_t[i]    = f0;
      fg1_t[i]    = f1;
      bg0_t[i]    = b0;
      bg1_t[i]    = b1;
      ctrl_t[i]   = c;
      bank_t[i]   = b;
      stream_t[i] = s;
      for (int k = 0; k < 8; k++)
         exp_t[i][k] = expected_index(i, k);
   endtask

   task automatic fill_table();
      logic [31:0] rnd [6];
      // single layer order, then flip per layer
      set_row(0, 8'hA5, 8'h0F, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0);
      set_row(1, 8'hA5, 8'h0F, 8'h00, 8'h00, 8'h01, 8'h00, 1'b0);
      set_row(2, 8'h00, 8'h00, 8'h3C, 8'h96, 8'h00, 8'h04, 1'b0);
      set_row(3, 8'hF0, 8'h00, 8'h00, 8'h33, 8'h02, 8'h09, 1'b0);
      // transparent gaps in both layers
      set_row(4, 8'hC0, 8'h00, 8'h03, 8'h00, 8'h00, 8'h0B, 1'b0);
      // full overlap with priority both ways
      set_row(5, 8'hFF, 8'h55, 8'hFF, 8'hAA, 8'h00, 8'h06, 1'b0);
      set_row(6, 8'hFF, 8'h55, 8'hFF, 8'hAA, 8'h04, 8'h06, 1'b0);
      set_row(7, 8'h5A, 8'hC3, 8'h69, 8'h1E, 8'h07, 8'h0F, 1'b0);
      // random tiles where the rows after the first stream back to back
      for (int i = 8; i < N_ROWS; i++)
      begin
         for (int j = 0; j < 6; j++)
            rnd[j] = $random(seed);
         set_row(i, rnd[0][7:0], rnd[1][7:0], rnd[2][7:0], rnd[3][7:0],
                 (i == 8) ? {5'b0, rnd[4][2:0]} : ctrl_t[8],
                 (i == 8) ? {4'b0, rnd[5][3:0]} : bank_t[8], i != 8);
      end
   endtask

   // ========================================================================
   // bus, tile and pixel helpers
   // ========================================================================

   task automatic apb_xfer(input logic wr, input sf_video_pkg::apb_addr_t addr,
                           input logic [7:0] wdata, output logic [7:0] rdata,
                           output logic err);
      @(posedge clk);
      paddr_i   <= addr;
      pwrite_i  <= wr;
      pwdata_i  <= wdata;
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      @(posedge clk);
      penable_i <= 1'b1;
      // middle of the access cycle
      @(negedge clk);
      rdata = prdata_o;
      err   = pslverr_o;
      check_value("pready in access", {7'b0, pready_o}, 8'h01);
      @(posedge clk);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
   endtask

   task automatic drive_tile(input int i);
      @(posedge clk);
      fg_plane0_i <= fg0_t[i];
      fg_plane1_i <= fg1_t[i];
      bg_plane0_i <= bg0_t[i];
      bg_plane1_i <= bg1_t[i];
   endtask

   // returns at the negedge of a load cycle
   task automatic wait_load();
      @(negedge clk);
      while (!tile_load_o)
         @(negedge clk);
   endtask

   task automatic next_pixel(output sf_video_pkg::color_index_t pix);
      @(negedge clk);
      while (!pixel_valid_o)
         @(negedge clk);
      pix = pixel_o;
   endtask

   task automatic check_value(input string what, input logic [7:0] got,
                              input logic [7:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         errors = errors + 1;
      end
   endtask

   task automatic finish_test(input string name);
      tests = tests + 1;
      if (errors != err_mark)
      begin
         failed = failed + 1;
         $display("test %s: FAIL", name);
      end
      else
         $display("test %s: ok", name);
   endtask

   // ========================================================================
   // test sequence
   // ========================================================================

   initial
   begin
      logic [7:0]                 rd;
      logic                       err;
      sf_video_pkg::color_index_t pix;
      clk         = 1'b1;
      CR          = 1'b0;
      paddr_i     = '0;
      psel_i      = 1'b0;
      penable_i   = 1'b0;
      pwrite_i    = 1'b0;
      pwdata_i    = '0;
      fg_plane0_i = '0;
      fg_plane1_i = '0;
      bg_plane0_i = '0;
      bg_plane1_i = '0;
      seed        = 32'h52c0_9bbb;
      errors      = 0;
      tests       = 0;
      failed      = 0;
      fill_table();

      err_mark = errors;
      for (int c = 0; c < 3; c++)
      begin
         @(negedge clk);
         if (tile_load_o || pixel_valid_o)
         begin
            $display("error at %0t ns: strobe or valid high during reset", $time);
            errors = errors + 1;
         end
      end
      @(posedge clk);
      CR <= 1'b1;
      apb_xfer(1'b0, CTRL_A, 8'h00, rd, err);
      check_value("ctrl after reset", rd, 8'h00);
      apb_xfer(1'b0, BANK_A, 8'h00, rd, err);
      check_value("bank after reset", rd, 8'h00);
      finish_test("reset");

      // unused bits read back as 0
      err_mark = errors;
      apb_xfer(1'b1, CTRL_A, 8'hFD, rd, err);
      check_value("ctrl write pslverr", {7'b0, err}, 8'h00);
      apb_xfer(1'b1, BANK_A, 8'hFE, rd, err);
      apb_xfer(1'b1, UNMAPPED_A, 8'hFF, rd, err);
      check_value("unmapped write pslverr", {7'b0, err}, 8'h01);
      apb_xfer(1'b0, UNMAPPED_A, 8'h00, rd, err);
      check_value("unmapped read pslverr", {7'b0, err}, 8'h01);
      check_value("unmapped read data", rd, 8'h00);
      apb_xfer(1'b0, CTRL_A, 8'h00, rd, err);
      check_value("ctrl readback", rd, 8'h05);
      apb_xfer(1'b0, BANK_A, 8'h00, rd, err);
      check_value("bank readback", rd, 8'h0E);
      finish_test("apb");

      for (int i = 0; i < N_ROWS; i++)
      begin
         err_mark = errors;
         if (!stream_t[i])
         begin
            apb_xfer(1'b1, CTRL_A, ctrl_t[i], rd, err);
            apb_xfer(1'b1, BANK_A, bank_t[i], rd, err);
            drive_tile(i);
            wait_load();
            wait_load();
         end
         // next tile goes in while this one is in flight
         if (i + 1 < N_ROWS && stream_t[i + 1])
            drive_tile(i + 1);
         // first pulse still carries the previous tile
         if (!stream_t[i])
            next_pixel(pix);
         for (int k = 0; k < 8; k++)
         begin
            next_pixel(pix);
            check_value($sformatf("row %0d pixel %0d", i, k), {3'b0, pix},
                        {3'b0, exp_t[i][k]});
         end
         finish_test($sformatf("tile row %0d", i));
      end

      $display("summary: %0d tests run, %0d with errors, %0d errors in total",
               tests, failed, errors);
      if (errors == 0 && failed == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   // watchdog sized from rows x tiles x pixels x clocks x period
   initial
   begin
      #(N_ROWS * 12 * sf_video_pkg::TILE_W * CLK_DIV * 20);
      $display("timeout: the pixel stream or bus did not finish in time");
      $display("tests failed");
      $finish;
   end

endmodule

/* verilog/layer_priority_mixer.sv */
// fg/bg priority mixer producing a registered colour index and valid pulse
`timescale 1ns/10ps

module layer_priority_mixer (
   input  logic                       clk,
   input  logic                       CR,
   input  logic                       pix_cen_i,
   input  sf_video_pkg::pix_code_t    fg_code_i,
   input  sf_video_pkg::pix_code_t    bg_code_i,
   input  logic                       fg_over_bg_i,
   input  sf_video_pkg::pal_bank_t    fg_bank_i,
   input  sf_video_pkg::pal_bank_t    bg_bank_i,
   output sf_video_pkg::color_index_t pixel_o,
   output logic                       pixel_valid_o
);

   logic                       fg_opaque;
   logic                       bg_opaque;
   logic                       fg_wins;
   sf_video_pkg::color_index_t mix_index;
   sf_video_pkg::color_index_t pixel_q;
   logic                       valid_q;

   // ========================================================================
   // layer selection
   // ========================================================================

   assign fg_opaque = |fg_code_i;
   assign bg_opaque = |bg_code_i;

   // fg takes the pixel alone, or on overlap when priority says so
   assign fg_wins = fg_opaque && (!bg_opaque || fg_over_bg_i);

   always_comb
   begin
      if (!fg_opaque && !bg_opaque)
         mix_index = '0;
      else if (fg_wins)
         mix_index = {1'b1, fg_bank_i, fg_code_i};
      else
         mix_index = {1'b0, bg_bank_i, bg_code_i};
   end

   // ========================================================================
   // output register
   // ========================================================================

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         pixel_q <= '0;
         valid_q <= 1'b0;
      end
      else
      begin
         if (pix_cen_i)
            pixel_q <= mix_index;
         // one clk wide, right after each pixel enable
         valid_q <= pix_cen_i;
      end
   end

   assign pixel_o       = pixel_q;
   assign pixel_valid_o = valid_q;

endmodule

/* verilog/pixel_timing.sv */
// pixel clock enable divider and tile load strobe generator
`timescale 1ns/10ps

module pixel_timing #(
   parameter int CLK_DIV = 8
) (
   input  logic clk,
   input  logic CR,
   output logic pix_cen_o,
   output logic tile_load_o
);

   localparam int DIV_W = $clog2(CLK_DIV);
   localparam int CNT_W = $clog2(sf_video_pkg::TILE_W);

   logic [DIV_W-1:0] div_q;
   logic             pix_cen_q;
   logic [CNT_W-1:0] pix_cnt_q;

   // ========================================================================
   // divide counter, one enable per CLK_DIV cycles
   // ========================================================================

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         div_q     <= '0;
         pix_cen_q <= 1'b0;
      end
      else
      begin
         if (div_q == DIV_W'(CLK_DIV - 1))
            div_q <= '0;
         else
            div_q <= div_q + 1'b1;
         // registered so the enable is a clean single-cycle pulse
         pix_cen_q <= (div_q == DIV_W'(CLK_DIV - 1));
      end
   end

   // pixel position within the tile row
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
         pix_cnt_q <= '0;
      else if (pix_cen_q)
         pix_cnt_q <= pix_cnt_q + 1'b1;
   end

   assign pix_cen_o   = pix_cen_q;
   // last pixel of the row, serializers reload here
   assign tile_load_o = pix_cen_q && (pix_cnt_q == CNT_W'(sf_video_pkg::TILE_W - 1));

endmodule

/* verilog/plane_serializer.sv */
// two-bitplane tile shifter with parallel load and flip-selected direction
`timescale 1ns/10ps

module plane_serializer (
   input  logic                      clk,
   input  logic                      CR,
   input  logic                      pix_cen_i,
   input  logic                      tile_load_i,
   input  logic                      flip_i,
   input  sf_video_pkg::plane_byte_t plane0_i,
   input  sf_video_pkg::plane_byte_t plane1_i,
   output sf_video_pkg::pix_code_t   code_o
);

   localparam int HEAD = sf_video_pkg::TILE_W - 1;

   sf_video_pkg::plane_byte_t plane0_q;
   sf_video_pkg::plane_byte_t plane1_q;

   // ========================================================================
   // shift helpers, same for both planes
   // ========================================================================

   // unflipped shifts left (msb out first), flipped shifts right
   function automatic sf_video_pkg::plane_byte_t shift_plane(
      input sf_video_pkg::plane_byte_t q,
      input logic                      flip
   );
      if (flip)
         return {1'b0, q[HEAD:1]};
      else
         return {q[HEAD-1:0], 1'b0};
   endfunction

   // bit currently at the output end
   function automatic logic head_bit(
      input sf_video_pkg::plane_byte_t q,
      input logic                      flip
   );
      return flip ? q[0] : q[HEAD];
   endfunction

   // ========================================================================
   // load on the tile strobe, otherwise shift one pixel per enable
   // ========================================================================

   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         plane0_q <= '0;
         plane1_q <= '0;
      end
      else if (tile_load_i)
      begin
         plane0_q <= plane0_i;
         plane1_q <= plane1_i;
      end
      else if (pix_cen_i)
      begin
         plane0_q <= shift_plane(plane0_q, flip_i);
         plane1_q <= shift_plane(plane1_q, flip_i);
      end
   end

   // plane 1 is the high code bit
   assign code_o = {head_bit(plane1_q, flip_i), head_bit(plane0_q, flip_i)};

endmodule

/* verilog/sf_video_pkg.sv */
// shared widths, register map and tile geometry for the two-layer pixel path

package sf_video_pkg;

   // ========================================================================
   // data widths
   // ========================================================================

   // one bitplane byte of an 8-pixel tile row
   typedef logic [7:0] plane_byte_t;

   // pixel code, plane 1 bit over plane 0 bit; 0 is transparent
   typedef logic [1:0] pix_code_t;

   // palette bank number
   typedef logic [1:0] pal_bank_t;

   // layer id over bank over code
   typedef logic [4:0] color_index_t;

   // apb address and data
   typedef logic [3:0] apb_addr_t;
   typedef logic [7:0] apb_data_t;

   // ========================================================================
   // geometry and register map
   // ========================================================================

   // pixels per tile row
   localparam int TILE_W = 8;

   // control register
   //   bit 0 fg flip, bit 1 bg flip, bit 2 fg over bg
   localparam int CTRL_ADDR = 0;

   // bank register
   //   bits 1..0 fg bank, bits 3..2 bg bank
   localparam int BANK_ADDR = 1;

endpackage

/* verilog/sf_video_top.sv */
// two-layer tile pixel path: timing, config registers, serializers and mixer
`timescale 1ns/10ps

module sf_video_top #(
   parameter int CLK_DIV = 8
) (
   input  logic                      clk,
   input  logic                      CR,

   // apb slave
   input  sf_video_pkg::apb_addr_t   paddr_i,
   input  logic                      psel_i,
   input  logic                      penable_i,
   input  logic                      pwrite_i,
   input  sf_video_pkg::apb_data_t   pwdata_i,
   output sf_video_pkg::apb_data_t   prdata_o,
   output logic                      pready_o,
   output logic                      pslverr_o,

   // tile rows, sampled on the load strobe
   input  sf_video_pkg::plane_byte_t fg_plane0_i,
   input  sf_video_pkg::plane_byte_t fg_plane1_i,
   input  sf_video_pkg::plane_byte_t bg_plane0_i,
   input  sf_video_pkg::plane_byte_t bg_plane1_i,

   output logic                      tile_load_o,
   output sf_video_pkg::color_index_t pixel_o,
   output logic                      pixel_valid_o
);

   logic                    pix_cen;
   logic                    tile_load;
   logic                    fg_flip;
   logic                    bg_flip;
   logic                    fg_over_bg;
   sf_video_pkg::pal_bank_t fg_bank;
   sf_video_pkg::pal_bank_t bg_bank;
   sf_video_pkg::pix_code_t fg_code;
   sf_video_pkg::pix_code_t bg_code;

   assign tile_load_o = tile_load;

   // ========================================================================
   // pixel clock enable and tile strobe
   // ========================================================================

   pixel_timing #(
      .CLK_DIV     (CLK_DIV)
   ) i_pixel_timing (
      .clk         (clk),
      .CR          (CR),
      .pix_cen_o   (pix_cen),
      .tile_load_o (tile_load)
   );

   video_cfg_regs i_video_cfg_regs (
      .clk          (clk),
      .CR           (CR),
      .paddr_i      (paddr_i),
      .psel_i       (psel_i),
      .penable_i    (penable_i),
      .pwrite_i     (pwrite_i),
      .pwdata_i     (pwdata_i),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o),
      .fg_flip_o    (fg_flip),
      .bg_flip_o    (bg_flip),
      .fg_over_bg_o (fg_over_bg),
      .fg_bank_o    (fg_bank),
      .bg_bank_o    (bg_bank)
   );

   // ========================================================================
   // layer serializers
   // ========================================================================

   plane_serializer i_fg_serializer (
      .clk         (clk),
      .CR          (CR),
      .pix_cen_i   (pix_cen),
      .tile_load_i (tile_load),
      .flip_i      (fg_flip),
      .plane0_i    (fg_plane0_i),
      .plane1_i    (fg_plane1_i),
      .code_o      (fg_code)
   );

   plane_serializer i_bg_serializer (
      .clk         (clk),
      .CR          (CR),
      .pix_cen_i   (pix_cen),
      .tile_load_i (tile_load),
      .flip_i      (bg_flip),
      .plane0_i    (bg_plane0_i),
      .plane1_i    (bg_plane1_i),
      .code_o      (bg_code)
   );

   layer_priority_mixer i_layer_priority_mixer (
      .clk           (clk),
      .CR            (CR),
      .pix_cen_i     (pix_cen),
      .fg_code_i     (fg_code),
      .bg_code_i     (bg_code),
      .fg_over_bg_i  (fg_over_bg),
      .fg_bank_i     (fg_bank),
      .bg_bank_i     (bg_bank),
      .pixel_o       (pixel_o),
      .pixel_valid_o (pixel_valid_o)
   );

endmodule

/* verilog/video_cfg_regs.sv */
// apb register block for layer flip, priority and palette bank settings
`timescale 1ns/10ps

module video_cfg_regs (
   input  logic                    clk,
   input  logic                    CR,
   input  sf_video_pkg::apb_addr_t paddr_i,
   input  logic                    psel_i,
   input  logic                    penable_i,
   input  logic                    pwrite_i,
   input  sf_video_pkg::apb_data_t pwdata_i,
   output sf_video_pkg::apb_data_t prdata_o,
   output logic                    pready_o,
   output logic                    pslverr_o,
   output logic                    fg_flip_o,
   output logic                    bg_flip_o,
   output logic                    fg_over_bg_o,
   output sf_video_pkg::pal_bank_t fg_bank_o,
   output sf_video_pkg::pal_bank_t bg_bank_o
);

   logic                    access;
   logic                    hit_ctrl;
   logic                    hit_bank;
   logic                    fg_flip_q;
   logic                    bg_flip_q;
   logic                    fg_over_bg_q;
   sf_video_pkg::pal_bank_t fg_bank_q;
   sf_video_pkg::pal_bank_t bg_bank_q;

   // ========================================================================
   // address decode, zero wait states
   // ========================================================================

   assign access   = psel_i && penable_i;
   assign hit_ctrl = (paddr_i == sf_video_pkg::apb_addr_t'(sf_video_pkg::CTRL_ADDR));
   assign hit_bank = (paddr_i == sf_video_pkg::apb_addr_t'(sf_video_pkg::BANK_ADDR));

   assign pready_o  = 1'b1;
   assign pslverr_o = access && !hit_ctrl && !hit_bank;

   // writes land at the end of the access cycle
   always_ff @(posedge clk or negedge CR)
   begin
      if (!CR)
      begin
         fg_flip_q    <= 1'b0;
         bg_flip_q    <= 1'b0;
         fg_over_bg_q <= 1'b0;
         fg_bank_q    <= '0;
         bg_bank_q    <= '0;
      end
      else if (access && pwrite_i)
      begin
         if (hit_ctrl)
         begin
            fg_flip_q    <= pwdata_i[0];
            bg_flip_q    <= pwdata_i[1];
            fg_over_bg_q <= pwdata_i[2];
         end
         if (hit_bank)
         begin
            fg_bank_q <= pwdata_i[1:0];
            bg_bank_q <= pwdata_i[3:2];
         end
      end
   end

   // readback, unused bits and unmapped addresses read 0
   always_comb
   begin
      prdata_o = '0;
      if (access && hit_ctrl)
         prdata_o = {5'b0, fg_over_bg_q, bg_flip_q, fg_flip_q};
      else if (access && hit_bank)
         prdata_o = {4'b0, bg_bank_q, fg_bank_q};
   end

   assign fg_flip_o    = fg_flip_q;
   assign bg_flip_o    = bg_flip_q;
   assign fg_over_bg_o = fg_over_bg_q;
   assign fg_bank_o    = fg_bank_q;
   assign bg_bank_o    = bg_bank_q;

endmodule
